// File: rtl/eqPkg.sv
package eqPkg;

    localparam int numBands     = 13;   // equalizer bands mixed per output word
    localparam int sampleWidth  = 16;   // band sample, gain and output word width
    localparam int axiAddrWidth = 6;
    localparam int axiDataWidth = 32;

    // gain register map, one word per band
    localparam int gainBaseAddr = 4;    // band 0
    localparam int gainLastAddr = gainBaseAddr + 4 * (numBands - 1);  // band 12, byte 52

    typedef logic signed [sampleWidth-1:0] sampleT;
    typedef sampleT [numBands-1:0] bandVecT;   // all bands or all gains side by side

    localparam sampleT gainReset = 16'h7fff;   // just below unity

    // half an lsb of the Q15 product, added before the cut
    localparam logic signed [2*sampleWidth-1:0] roundConst = 32'h00004000;

    localparam logic [1:0] axiRespOkay = 2'b00;

    typedef enum logic {
        wrIdle,     // address and data accepted together
        wrResp      // holding BVALID
    } wrStateT;

    typedef enum logic {
        rdIdle,
        rdData      // holding RVALID and RDATA
    } rdStateT;

endpackage

// File: rtl/axiLiteGainRegs.sv
`timescale 1ns/1ps

module axiLiteGainRegs
    import eqPkg::*;
(
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic [axiAddrWidth-1:0] S_AXI_AWADDR,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    input  logic [axiDataWidth-1:0] S_AXI_WDATA,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    output logic [1:0]              S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic                    S_AXI_BREADY,
    input  logic [axiAddrWidth-1:0] S_AXI_ARADDR,
    input  logic                    S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,
    output logic [axiDataWidth-1:0] S_AXI_RDATA,
    output logic [1:0]              S_AXI_RRESP,
    output logic                    S_AXI_RVALID,
    input  logic                    S_AXI_RREADY,
    output bandVecT                 gains
);

    wrStateT                 wrState;
    rdStateT                 rdState;
    logic                    wrAccept;
    logic                    rdAccept;
    logic [axiDataWidth-1:0] rdWord;    // registered read data

    // word aligned and inside the gain window
    function automatic logic addrHit(input logic [axiAddrWidth-1:0] addr);
        addrHit = (addr[1:0] == 2'b00) && (addr >= gainBaseAddr) && (addr <= gainLastAddr);
    endfunction

    // band number of a mapped address
    function automatic logic [axiAddrWidth-3:0] gainIndex(input logic [axiAddrWidth-1:0] addr);
        logic [axiAddrWidth-1:0] offset;
        offset    = addr - axiAddrWidth'(gainBaseAddr);
        gainIndex = offset[axiAddrWidth-1:2];
    endfunction

    assign S_AXI_AWREADY = (wrState == wrIdle);
    assign S_AXI_WREADY  = (wrState == wrIdle);     // both channels taken on one edge
    assign S_AXI_BVALID  = (wrState == wrResp);
    assign S_AXI_BRESP   = axiRespOkay;             // unmapped writes are dropped silently

    assign S_AXI_ARREADY = (rdState == rdIdle);
    assign S_AXI_RVALID  = (rdState == rdData);
    assign S_AXI_RRESP   = axiRespOkay;
    assign S_AXI_RDATA   = rdWord;

    assign wrAccept = S_AXI_AWVALID && S_AXI_WVALID && S_AXI_AWREADY && S_AXI_WREADY;
    assign rdAccept = S_AXI_ARVALID && S_AXI_ARREADY;

    // write channel and gain storage
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wrState <= wrIdle;
            gains   <= {numBands{gainReset}};
        end else begin
            case (wrState)
                wrIdle: begin
                    if (wrAccept) begin
                        wrState <= wrResp;
                        if (addrHit(S_AXI_AWADDR)) begin
                            gains[gainIndex(S_AXI_AWADDR)] <= S_AXI_WDATA[sampleWidth-1:0];
                        end
                    end
                end
                wrResp: begin
                    if (S_AXI_BREADY) begin
                        wrState <= wrIdle;
                    end
                end
                default: wrState <= wrIdle;
            endcase
        end
    end

    // read channel
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rdState <= rdIdle;
        end else begin
            case (rdState)
                rdIdle: begin
                    if (rdAccept) begin
                        rdState <= rdData;
                    end
                end
                rdData: begin
                    if (S_AXI_RREADY) begin
                        rdState <= rdIdle;
                    end
                end
                default: rdState <= rdIdle;
            endcase
        end
    end

    // read word only loads on the address handshake, so it holds while RVALID waits
    always_ff @(posedge S_AXI_ACLK) begin
        if (rdAccept) begin
            if (addrHit(S_AXI_ARADDR)) begin
                rdWord <= {{(axiDataWidth-sampleWidth){gains[gainIndex(S_AXI_ARADDR)][sampleWidth-1]}},
                           gains[gainIndex(S_AXI_ARADDR)]};    // sign extend
            end else begin
                rdWord <= '0;
            end
        end
    end

    // response held until the manager takes it
    bvalidHold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

    // read data stays put while the manager stalls
    rdataHold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

// File: rtl/bandMixer.sv
`timescale 1ns/1ps

module bandMixer
    import eqPkg::*;
(
    input  logic    S_AXI_ACLK,
    input  logic    S_AXI_ARESETN,
    input  bandVecT bandIn,
    input  logic    bandValid,
    input  bandVecT gains,
    output sampleT  mixSum,
    output logic    mixValid
);

    logic signed [2*sampleWidth-1:0] product [numBands];   // gain * sample + rounding
    bandVecT termD;
    bandVecT termQ;         // stage one, rounded Q15 terms
    logic    termValid;
    sampleT  sumD;

    // stage one math
    always_comb begin
        for (int k = 0; k < numBands; k++) begin
            product[k] = $signed(gains[k]) * $signed(bandIn[k]) + roundConst;
            termD[k]   = product[k][2*sampleWidth-2:sampleWidth-1];  // drop Q15 fraction
        end
    end

    // stage two math, 16-bit sum that wraps like the DAC path expects
    always_comb begin
        sumD = '0;
        for (int k = 0; k < numBands; k++) begin
            sumD = sumD + termQ[k];
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            termValid <= 1'b0;
            mixValid  <= 1'b0;
        end else begin
            termValid <= bandValid;
            mixValid  <= termValid;
        end
    end

    // payload registers, qualified by the valid pipe above
    always_ff @(posedge S_AXI_ACLK) begin
        termQ  <= termD;    // gains as they stand when the strobe is sampled
        mixSum <= sumD;
    end

    // every strobe produces a sum two cycles later
    mixLatency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bandValid |-> ##2 mixValid);

    // and no sum appears without one
    mixOrigin: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        mixValid |-> $past(bandValid, 2));

endmodule

// File: rtl/dacSampleFormatter.sv
`timescale 1ns/1ps

module dacSampleFormatter
    import eqPkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    input  sampleT                 mixSum,
    input  logic                   mixValid,
    output logic [sampleWidth-1:0] dacWord,
    output logic                   dacChannel,
    output logic                   dacValid
);

    logic nextChannel;  // tag for the next word, 0 is left

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            dacValid    <= 1'b0;
            dacChannel  <= 1'b0;
            nextChannel <= 1'b0;
        end else begin
            dacValid <= mixValid;
            if (mixValid) begin
                dacChannel  <= nextChannel;
                nextChannel <= ~nextChannel;    // left and right alternate per word
            end
        end
    end

    // two's complement to offset binary
    always_ff @(posedge S_AXI_ACLK) begin
        if (mixValid) begin
            dacWord <= {~mixSum[sampleWidth-1], mixSum[sampleWidth-2:0]};
        end
    end

endmodule

// File: rtl/equalizerTop.sv
`timescale 1ns/1ps

module equalizerTop
    import eqPkg::*;
(
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic [axiAddrWidth-1:0] S_AXI_AWADDR,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    input  logic [axiDataWidth-1:0] S_AXI_WDATA,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    output logic [1:0]              S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic                    S_AXI_BREADY,
    input  logic [axiAddrWidth-1:0] S_AXI_ARADDR,
    input  logic                    S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,
    output logic [axiDataWidth-1:0] S_AXI_RDATA,
    output logic [1:0]              S_AXI_RRESP,
    output logic                    S_AXI_RVALID,
    input  logic                    S_AXI_RREADY,
    input  bandVecT                 bandIn,
    input  logic                    bandValid,
    output logic [sampleWidth-1:0]  dacWord,
    output logic                    dacChannel,
    output logic                    dacValid
);

    bandVecT gains;     // only moves on AXI write handshakes
    sampleT  mixSum;
    logic    mixValid;

    axiLiteGainRegs gainRegs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .gains         (gains)
    );

    // two cycles, strobe to sum
    bandMixer mixer (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .bandIn        (bandIn),
        .bandValid     (bandValid),
        .gains         (gains),
        .mixSum        (mixSum),
        .mixValid      (mixValid)
    );

    // one more cycle to the DAC word
    dacSampleFormatter formatter (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .mixSum        (mixSum),
        .mixValid      (mixValid),
        .dacWord       (dacWord),
        .dacChannel    (dacChannel),
        .dacValid      (dacValid)
    );

endmodule

// File: verif/equalizerTb.sv
`timescale 1ns/1ps

module equalizerTb
    import eqPkg::*;
();

    localparam int waitLimit  = 20;     // cycles per handshake wait
    localparam int runLimit   = 20000;  // whole-run watchdog

    logic                    S_AXI_ACLK;
    logic                    S_AXI_ARESETN;
    logic [axiAddrWidth-1:0] S_AXI_AWADDR;
    logic                    S_AXI_AWVALID;
    logic                    S_AXI_AWREADY;
    logic [axiDataWidth-1:0] S_AXI_WDATA;
    logic                    S_AXI_WVALID;
    logic                    S_AXI_WREADY;
    logic [1:0]              S_AXI_BRESP;
    logic                    S_AXI_BVALID;
    logic                    S_AXI_BREADY;
    logic [axiAddrWidth-1:0] S_AXI_ARADDR;
    logic                    S_AXI_ARVALID;
    logic                    S_AXI_ARREADY;
    logic [axiDataWidth-1:0] S_AXI_RDATA;
    logic [1:0]              S_AXI_RRESP;
    logic                    S_AXI_RVALID;
    logic                    S_AXI_RREADY;
    bandVecT                 bandIn;
    logic                    bandValid;
    logic [sampleWidth-1:0]  dacWord;
    logic                    dacChannel;
    logic                    dacValid;

    sampleT            modelGain [numBands];   // shadow of the gain registers
    int                dueQ [$];               // cycle at which each word is due
    logic [15:0]       wordQ [$];
    int                cycleCount;
    logic              expValid;
    logic [15:0]       expWord;
    logic              expChannel;
    logic              nextChannel;
    string             testName;
    int                mismatchCount;
    int                timeoutCount;
    int                otherCount;

    equalizerTop dut (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // rounded Q15 terms, 16-bit wrapping sum, MSB flipped for offset binary
    function automatic logic [15:0] mixWord(input bandVecT bands);
        longint acc;
        longint prod;
        acc = 0;
        for (int k = 0; k < numBands; k++) begin
            prod = longint'($signed(modelGain[k])) * longint'($signed(bands[k])) + 64'sd16384;
            acc  = acc + ((prod >>> 15) & 64'hffff);    // bits 30 down to 15
        end
        return {~acc[15], acc[14:0]};
    endfunction

    // expected DAC stream, one word per strobe, three cycles later
    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            dueQ.delete();
            wordQ.delete();
            cycleCount  <= 0;
            expValid    <= 1'b0;
            expWord     <= '0;
            expChannel  <= 1'b0;
            nextChannel <= 1'b0;
        end else begin
            cycleCount <= cycleCount + 1;
            expValid   <= 1'b0;
            if (dueQ.size() > 0 && dueQ[0] == cycleCount + 1) begin    // loaded one edge ahead
                expValid    <= 1'b1;
                expWord     <= wordQ[0];
                expChannel  <= nextChannel;
                nextChannel <= ~nextChannel;   // left, right, left...
                void'(wordQ.pop_front());
                void'(dueQ.pop_front());
            end
            if (bandValid) begin
                dueQ.push_back(cycleCount + 3);
                wordQ.push_back(mixWord(bandIn));
            end
        end
    end

    validCheck: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        dacValid == expValid)
        else begin
            $display("mismatch %s dacValid: expected %0b, actual %0b",
                     testName, $sampled(expValid), $sampled(dacValid));
            mismatchCount++;
        end

    wordCheck: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        dacValid |-> dacWord == expWord)
        else begin
            $display("mismatch %s dacWord: expected %h, actual %h",
                     testName, $sampled(expWord), $sampled(dacWord));
            mismatchCount++;
        end

    channelCheck: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        dacChannel == expChannel)
        else begin
            $display("mismatch %s dacChannel: expected %0b, actual %0b",
                     testName, $sampled(expChannel), $sampled(dacChannel));
            mismatchCount++;
        end

    task automatic axiWrite(input logic [axiAddrWidth-1:0] addr,
                            input logic [axiDataWidth-1:0] data, input int stall);
        int waitCount;
        int a;
        a             = int'(addr);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        S_AXI_BREADY  = 1'b0;
        waitCount     = 0;
        while (!(S_AXI_AWREADY && S_AXI_WREADY) && waitCount < waitLimit) begin
            @(posedge S_AXI_ACLK);
            #1;
            waitCount++;
        end
        if (!(S_AXI_AWREADY && S_AXI_WREADY)) begin
            $display("timeout in %s: write to address %0d was not accepted", testName, a);
            timeoutCount++;
        end
        @(posedge S_AXI_ACLK);  // handshake edge
        #1;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        if (a[1:0] == 2'b00 && a >= 4 && a <= 52) begin
            modelGain[(a - 4) / 4] = data[15:0];
        end
        waitCount = 0;
        while (!S_AXI_BVALID && waitCount < waitLimit) begin
            @(posedge S_AXI_ACLK);
            #1;
            waitCount++;
        end
        if (!S_AXI_BVALID) begin
            $display("timeout in %s: no write response for address %0d", testName, a);
            timeoutCount++;
        end else begin
            assert (S_AXI_BRESP == axiRespOkay) else begin
                $display("mismatch %s BRESP: expected %b, actual %b",
                         testName, axiRespOkay, S_AXI_BRESP);
                mismatchCount++;
            end
            repeat (stall) begin
                @(posedge S_AXI_ACLK);
                #1;
                assert (S_AXI_BVALID) else begin
                    $display("BVALID dropped in %s before BREADY was raised", testName);
                    otherCount++;
                end
            end
            S_AXI_BREADY = 1'b1;
            @(posedge S_AXI_ACLK);
            #1;
            S_AXI_BREADY = 1'b0;
        end
    endtask

    task automatic axiRead(input logic [axiAddrWidth-1:0] addr,
                           input logic [axiDataWidth-1:0] expected, input int stall);
        int                      waitCount;
        logic [axiDataWidth-1:0] held;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        S_AXI_RREADY  = 1'b0;
        waitCount     = 0;
        while (!S_AXI_ARREADY && waitCount < waitLimit) begin
            @(posedge S_AXI_ACLK);
            #1;
            waitCount++;
        end
        if (!S_AXI_ARREADY) begin
            $display("timeout in %s: read of address %0d was not accepted", testName, addr);
            timeoutCount++;
        end
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARVALID = 1'b0;
        waitCount     = 0;
        while (!S_AXI_RVALID && waitCount < waitLimit) begin
            @(posedge S_AXI_ACLK);
            #1;
            waitCount++;
        end
        if (!S_AXI_RVALID) begin
            $display("timeout in %s: no read data for address %0d", testName, addr);
            timeoutCount++;
        end else begin
            held = S_AXI_RDATA;
            assert (S_AXI_RDATA == expected && S_AXI_RRESP == axiRespOkay) else begin
                $display("mismatch %s read %0d: expected %h/%b, actual %h/%b", testName,
                         addr, expected, axiRespOkay, S_AXI_RDATA, S_AXI_RRESP);
                mismatchCount++;
            end
            repeat (stall) begin
                @(posedge S_AXI_ACLK);
                #1;
                assert (S_AXI_RVALID && S_AXI_RDATA == held) else begin
                    $display("read data in %s moved before RREADY was raised", testName);
                    otherCount++;
                end
            end
            S_AXI_RREADY = 1'b1;
            @(posedge S_AXI_ACLK);
            #1;
            S_AXI_RREADY = 1'b0;
        end
    endtask

    // back-to-back strobes with fresh random band samples
    task automatic sendBands(input int count);
        repeat (count) begin
            for (int k = 0; k < numBands; k++) begin
                bandIn[k] = 16'($urandom);
            end
            bandValid = 1'b1;
            @(posedge S_AXI_ACLK);
            #1;
        end
        bandValid = 1'b0;
    endtask

    task automatic drainOutputs();
        int waitCount;
        waitCount = 0;
        while (dueQ.size() > 0 && waitCount < waitLimit) begin
            @(posedge S_AXI_ACLK);
            #1;
            waitCount++;
        end
        if (dueQ.size() > 0) begin
            $display("timeout in %s: %0d words never reached the DAC", testName, dueQ.size());
            timeoutCount++;
        end
        @(posedge S_AXI_ACLK);  // last word is checked on this edge
        #1;
    endtask

    task automatic finishRun();
        $display("errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatchCount, timeoutCount, otherCount);
        if (mismatchCount + timeoutCount + otherCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        repeat (runLimit) @(posedge S_AXI_ACLK);
        $display("run did not complete within %0d cycles", runLimit);
        timeoutCount++;
        finishRun();
    end

    initial begin
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        bandIn        = '0;
        bandValid     = 1'b0;
        mismatchCount = 0;
        timeoutCount  = 0;
        otherCount    = 0;
        testName      = "reset";
        void'($urandom(83852));
        for (int k = 0; k < numBands; k++) begin
            modelGain[k] = 16'h7fff;
        end
        repeat (10) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        @(posedge S_AXI_ACLK);
        #1;
        assert (S_AXI_AWREADY && S_AXI_WREADY && S_AXI_ARREADY) else begin
            $display("AXI ready outputs are not high one cycle after reset");
            otherCount++;
        end

        testName = "resetGains";
        for (int k = 0; k < numBands; k++) begin
            axiRead(6'(4 + 4 * k), 32'h0000_7fff, 0);
        end

        testName = "gainReadback";
        for (int k = 0; k < numBands; k++) begin
            axiWrite(6'(4 + 4 * k), $urandom, 0);
        end
        for (int k = 0; k < numBands; k++) begin
            axiRead(6'(4 + 4 * k), {{16{modelGain[k][15]}}, modelGain[k]}, 0);
        end

        testName = "unmapped";
        axiWrite(6'd0, 32'h0000_1234, 0);
        axiWrite(6'd56, 32'h0000_5678, 0);
        axiWrite(6'd6, 32'h0000_9abc, 0);   // misaligned, inside the window
        for (int k = 0; k < numBands; k++) begin
            axiRead(6'(4 + 4 * k), {{16{modelGain[k][15]}}, modelGain[k]}, 0);
        end
        axiRead(6'd0, 32'h0, 0);
        axiRead(6'd56, 32'h0, 0);

        testName = "mixRandom";
        repeat (12) begin
            sendBands(1);
            repeat ($urandom % 4) begin
                @(posedge S_AXI_ACLK);
                #1;
            end
        end
        drainOutputs();

        testName = "burst";
        for (int k = 0; k < numBands; k++) begin
            axiWrite(6'(4 + 4 * k), $urandom, 0);
        end
        sendBands(9);
        drainOutputs();

        testName = "stall";
        axiWrite(6'd20, 32'h0000_8001, 4);
        axiRead(6'd20, 32'hffff_8001, 5);
        axiRead(6'd56, 32'h0, 3);
        finishRun();
    end

endmodule

// File: src.f
rtl/eqPkg.sv
rtl/axiLiteGainRegs.sv
rtl/bandMixer.sv
rtl/dacSampleFormatter.sv
rtl/equalizerTop.sv
verif/equalizerTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module equalizerTb -Mdir obj_dir -f src.f

out=$(./obj_dir/VequalizerTb)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
